// ==== src.f ====
+incdir+.
aui_pkg.sv
aui_marker_pkg.sv
aui_frame_counter.sv
aui_pipe_reg.sv
aui_lane_mapper.sv
aui_lane_generator.sv
tb_aui_lane_generator.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

( verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_aui_lane_generator -o sim_tb \
    && ./obj_dir/sim_tb ) > sim.log 2>&1

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No pass result, see sim.log"; exit 1; }
echo "Simulation passed"

// ==== tb_aui_lane_generator.sv ====
`timescale 1ns/1ns
`include "aui_settings.svh"

module tb_aui_lane_generator;

    localparam int NUM_FRAMES      = 6;
    localparam int TOTAL_WORDS     = NUM_FRAMES * `AUI_FRAME_WORDS;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 8 + 100;

    logic               clk = 1'b0;
    logic               rst;
    logic               i_ready;
    logic               o_valid;
    aui_pkg::lane_bus_t o_lanes;

    logic [31:0]        lfsr = 32'h127eb924;
    logic [1:0]         ready_bits;

    // Reference model state
    int                        model_idx = 0;
    logic [`AUI_PRBS_BITS-1:0] model_prbs [`AUI_LANES];

    aui_pkg::lane_bus_t exp_lanes;
    aui_pkg::lane_bus_t held_lanes;
    logic               hold_pending = 1'b0;
    int                 words_done = 0;

    aui_lane_generator u_aui_lane_generator (
        .clk     (clk),
        .rst     (rst),
        .i_ready (i_ready),
        .o_valid (o_valid),
        .o_lanes (o_lanes)
    );

    always #5 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_lanes(input string name, input aui_pkg::lane_bus_t got,
                                 input aui_pkg::lane_bus_t exp);
        int l;
        for (l = 0; l < `AUI_LANES; l++) begin
            if (got.words[l] !== exp.words[l]) begin
                stop_on_error($sformatf("FAIL %s.words[%0d] got 0x%h expected 0x%h",
                                        name, l, got.words[l], exp.words[l]));
            end
        end
    endtask

    task automatic compare_sync(input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL o_lanes.sync got 0x%h expected 0x%h (word %0d)",
                                    got, exp, words_done));
        end
    endtask

    task automatic compare_valid(input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL o_valid got 0x%h expected 0x%h", got, exp));
        end
    endtask

    // Build the expected bus for the current word and advance the model
    task automatic predict_next(output aui_pkg::lane_bus_t bus);
        aui_pkg::lane_bus_t        next_bus;
        logic [`AUI_PRBS_BITS-1:0] s;
        logic                      fb;
        int                        l;
        int                        b;
        next_bus.sync = (model_idx == 0);
        for (l = 0; l < `AUI_LANES; l++) begin
            if (model_idx == 0) begin
                model_prbs[l] = `AUI_PRBS_BITS'(l + 1);
            end
            if (model_idx < `AUI_MARKER_WORDS) begin
                next_bus.words[l] = aui_pkg::lane_word_t'(
                    aui_marker_pkg::AM_TABLE[l] >> (model_idx * `AUI_WORD_BITS));
            end else if (model_idx == `AUI_STATUS_WORD) begin
                next_bus.words[l] = aui_marker_pkg::STATUS_WORD;
            end else begin
                s = model_prbs[l];
                // Oldest bit goes to the LSB
                for (b = 0; b < `AUI_WORD_BITS; b++) begin
                    fb = s[`AUI_PRBS_TAP_A-1] ^ s[`AUI_PRBS_TAP_B-1];
                    next_bus.words[l][b] = fb;
                    s = {s[`AUI_PRBS_BITS-2:0], fb};
                end
                model_prbs[l] = s;
            end
        end
        if (model_idx == `AUI_FRAME_WORDS - 1) begin
            model_idx = 0;
        end else begin
            model_idx = model_idx + 1;
        end
        bus = next_bus;
    endtask

    // Ready is high when either of two fresh bits is set
    always @(posedge clk) begin
        lfsr = lfsr_step(lfsr);
        ready_bits[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        ready_bits[1] = lfsr[0];
        i_ready <= |ready_bits;
    end

    // Handshake values seen here are the ones before the edge
    always @(posedge clk) begin
        if (!rst) begin
            // No gaps in the stream once the first word is out
            if (words_done > 0) begin
                compare_valid(o_valid, 1'b1);
            end
            if (hold_pending) begin
                compare_valid(o_valid, 1'b1);
                compare_lanes("o_lanes (stalled)", o_lanes, held_lanes);
                compare_sync(o_lanes.sync, held_lanes.sync);
                hold_pending = 1'b0;
            end
            if (o_valid && !i_ready) begin
                held_lanes   = o_lanes;
                hold_pending = 1'b1;
            end
            if (o_valid && i_ready) begin
                predict_next(exp_lanes);
                compare_lanes("o_lanes", o_lanes, exp_lanes);
                compare_sync(o_lanes.sync, exp_lanes.sync);
                words_done = words_done + 1;
            end
        end
    end

    initial begin : main_flow
        int wait_cycles;
        int l;
        rst     = 1'b1;
        i_ready = 1'b0;
        for (l = 0; l < `AUI_LANES; l++) begin
            model_prbs[l] = '0;
        end

        repeat (4) begin
            @(negedge clk);
            compare_valid(o_valid, 1'b0);
        end
        @(posedge clk);
        rst <= 1'b0;

        // First word must show up within 3 cycles
        wait_cycles = 0;
        @(negedge clk);
        while (!o_valid && wait_cycles < 3) begin
            @(negedge clk);
            wait_cycles = wait_cycles + 1;
        end
        if (!o_valid) begin
            stop_on_error("o_valid did not rise within 3 cycles after reset was released");
        end
        compare_sync(o_lanes.sync, 1'b1);

        wait (words_done >= TOTAL_WORDS);
        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error($sformatf("Timeout, outputs stalled after %0d of %0d words",
                                words_done, TOTAL_WORDS));
    end

endmodule

// ==== aui_lane_generator.sv ====
`timescale 1ns/1ns

module aui_lane_generator (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_ready,
    output logic               o_valid,
    output aui_pkg::lane_bus_t o_lanes
);

    logic                cnt_valid;
    logic                cnt_ready;
    aui_pkg::frame_pos_t cnt_pos;

    logic                pos_valid;
    logic                pos_ready;
    aui_pkg::frame_pos_t pos_data;

    logic                map_valid;
    logic                map_ready;
    aui_pkg::lane_bus_t  map_lanes;

    aui_frame_counter u_frame_counter (
        .clk     (clk),
        .rst     (rst),
        .i_ready (cnt_ready),
        .o_valid (cnt_valid),
        .o_pos   (cnt_pos)
    );

    aui_pipe_reg #(.T(aui_pkg::frame_pos_t)) u_pos_stage (
        .clk     (clk),
        .rst     (rst),
        .i_valid (cnt_valid),
        .o_ready (cnt_ready),
        .i_data  (cnt_pos),
        .o_valid (pos_valid),
        .i_ready (pos_ready),
        .o_data  (pos_data)
    );

    aui_lane_mapper u_lane_mapper (
        .clk     (clk),
        .rst     (rst),
        .i_valid (pos_valid),
        .o_ready (pos_ready),
        .i_pos   (pos_data),
        .o_valid (map_valid),
        .i_ready (map_ready),
        .o_lanes (map_lanes)
    );

    // Output stage
    aui_pipe_reg #(.T(aui_pkg::lane_bus_t)) u_lane_stage (
        .clk     (clk),
        .rst     (rst),
        .i_valid (map_valid),
        .o_ready (map_ready),
        .i_data  (map_lanes),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_data  (o_lanes)
    );

endmodule

// ==== aui_lane_mapper.sv ====
`timescale 1ns/1ns
`include "aui_settings.svh"

module aui_lane_mapper (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_valid,
    output logic                o_ready,
    input  aui_pkg::frame_pos_t i_pos,
    output logic                o_valid,
    input  logic                i_ready,
    output aui_pkg::lane_bus_t  o_lanes
);

    typedef logic [`AUI_PRBS_BITS-1:0] prbs_t;

    logic               xfer;
    aui_pkg::lane_word_t lane_word [`AUI_LANES];

    // No latency here, handshake goes straight through
    assign o_valid = i_valid;
    assign o_ready = i_ready;
    assign xfer    = i_valid && i_ready;

    for (genvar l = 0; l < `AUI_LANES; l++) begin : g_lane
        localparam prbs_t SEED = prbs_t'(l + 1);

        prbs_t               prbs_q;
        prbs_t               prbs_next;
        aui_pkg::lane_word_t prbs_bits;

        // 40 serial PRBS9 steps, first bit lands in the LSB
        always_comb begin
            prbs_next = prbs_q;
            for (int b = 0; b < `AUI_WORD_BITS; b++) begin
                prbs_bits[b] = prbs_next[`AUI_PRBS_TAP_A-1] ^ prbs_next[`AUI_PRBS_TAP_B-1];
                prbs_next    = {prbs_next[`AUI_PRBS_BITS-2:0], prbs_bits[b]};
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                prbs_q <= SEED;
            end else if (xfer) begin
                // Restart the pattern at every frame
                if (i_pos.first) begin
                    prbs_q <= SEED;
                end else if (i_pos.region == aui_pkg::REGION_PAYLOAD) begin
                    prbs_q <= prbs_next;
                end
            end
        end

        always_comb begin
            case (i_pos.region)
                aui_pkg::REGION_MARKER: begin
                    lane_word[l] = aui_marker_pkg::AM_TABLE[l][i_pos.idx*`AUI_WORD_BITS +:
                                                                `AUI_WORD_BITS];
                end
                aui_pkg::REGION_STATUS: begin
                    lane_word[l] = aui_marker_pkg::STATUS_WORD;
                end
                default: begin
                    lane_word[l] = prbs_bits;
                end
            endcase
        end
    end

    always_comb begin
        o_lanes.sync = i_pos.first;
        for (int l = 0; l < `AUI_LANES; l++) begin
            o_lanes.words[l] = lane_word[l];
        end
    end

endmodule

// ==== aui_pipe_reg.sv ====
`timescale 1ns/1ns

module aui_pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    logic valid_q;
    T     data_q;

    // Take new data when empty or when the held item leaves
    assign o_ready = !valid_q || i_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready && i_valid) begin
            data_q <= i_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

    // A stalled item stays put until taken
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

// ==== aui_frame_counter.sv ====
`timescale 1ns/1ns
`include "aui_settings.svh"

module aui_frame_counter (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_ready,
    output logic                o_valid,
    output aui_pkg::frame_pos_t o_pos
);

    localparam aui_pkg::word_idx_t LAST_IDX = aui_pkg::word_idx_t'(`AUI_FRAME_WORDS - 1);

    aui_pkg::word_idx_t idx_q;
    logic               valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            idx_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
            // Advance only on an accepted position
            if (valid_q && i_ready) begin
                if (idx_q == LAST_IDX) begin
                    idx_q <= '0;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    // Region decode
    always_comb begin
        o_pos.idx   = idx_q;
        o_pos.first = (idx_q == '0);
        if (idx_q < `AUI_MARKER_WORDS) begin
            o_pos.region = aui_pkg::REGION_MARKER;
        end else if (idx_q == `AUI_STATUS_WORD) begin
            o_pos.region = aui_pkg::REGION_STATUS;
        end else begin
            o_pos.region = aui_pkg::REGION_PAYLOAD;
        end
    end

    assign o_valid = valid_q;

    a_idx_in_frame: assert property (@(posedge clk) disable iff (rst)
        idx_q < `AUI_FRAME_WORDS);

endmodule

// ==== aui_marker_pkg.sv ====
`include "aui_settings.svh"

package aui_marker_pkg;

    // Per-lane markers, octet order already reversed
    localparam aui_pkg::marker_t AM_TABLE [`AUI_LANES] = '{
        120'hf37101260c8efed9d9b565b6264a9a,
        120'h7ede5a988121a567d9b56504264a9a,
        120'h56f33e01a90cc1fed9b56546264a9a,
        120'hd080867b2f7f7984d9b5655a264a9a,
        120'hf2512ae60daed519d9b565e1264a9a,
        120'hd14f12b12eb0ed4ed9b565f2264a9a,
        120'h3cc4715dc33b8ea2d9b5656b264a9a,
        120'h5b76d6cda4892932d9b56522264a9a,
        120'h7573e1608a8c1e9fd9b56560264a9a,
        120'ha19c42115e63bdeed9b5653d264a9a,
        120'h3866228ec799dd71d9b5656c264a9a,
        120'hd8eb95fb27146a04d9b565fa264a9a,
        120'h95f6a2a46a095d5bd9b56518264a9a,
        120'hc39731333c68ceccd9b56514264a9a,
        120'ha6fbca4e590435b1d9b565d0264a9a,
        120'h79baa6a986455956d9b565b4264a9a
    };

    // Three status bits on top, 0x6 pad below
    localparam aui_pkg::lane_word_t STATUS_WORD = {3'b111, 37'h0666666666};

endpackage

// ==== aui_pkg.sv ====
`include "aui_settings.svh"

package aui_pkg;

    typedef logic [`AUI_WORD_BITS-1:0] lane_word_t;

    // Full alignment marker, three lane words
    typedef logic [`AUI_MARKER_WORDS*`AUI_WORD_BITS-1:0] marker_t;

    typedef logic [$clog2(`AUI_FRAME_WORDS)-1:0] word_idx_t;

    typedef enum logic [1:0] {
        REGION_MARKER,
        REGION_STATUS,
        REGION_PAYLOAD
    } region_e;

    typedef struct packed {
        word_idx_t idx;
        region_e   region;
        logic      first;
    } frame_pos_t;

    // Lane 0 sits in words[0]
    typedef struct packed {
        lane_word_t [`AUI_LANES-1:0] words;
        logic                        sync;
    } lane_bus_t;

endpackage

// ==== aui_settings.svh ====
`ifndef AUI_SETTINGS_SVH
`define AUI_SETTINGS_SVH

// Lane and word geometry
`define AUI_LANES        16
`define AUI_SYMBOL_BITS  10
`define AUI_WORD_BITS    (4 * `AUI_SYMBOL_BITS)

// Frame layout, in words per lane
`define AUI_FRAME_WORDS  34
`define AUI_MARKER_WORDS 3
`define AUI_STATUS_WORD  3

// PRBS9, x^9 + x^5 + 1
`define AUI_PRBS_BITS    9
`define AUI_PRBS_TAP_A   9
`define AUI_PRBS_TAP_B   5

`endif
